// File: kbd_pkg.sv
// Shared types for the PS/2 keyboard front end.
// Holds the received frame, the decoded key event and the host
// status word, plus the two scan code prefix bytes.

package kbd_pkg;

   // Prefix bytes of scan code set 2.
   localparam logic [7:0] PREFIX_EXT   = 8'hE0; // Extended key follows.
   localparam logic [7:0] PREFIX_BREAK = 8'hF0; // Key release follows.

   // One byte as taken off the line, before the parity check.
   typedef struct packed {
      logic [7:0] code;   // Data bits, LSB first on the wire.
      logic       parity; // Received parity bit.
   } ps2_frame_t;

   // One key action after prefix folding.
   // The release flag is named released since release is a keyword.
   typedef struct packed {
      logic       extended; // E0 came before the code.
      logic       released; // F0 came before the code.
      logic [7:0] code;     // Final scan code byte.
   } key_event_t;

   // Status word seen by the host.
   typedef struct packed {
      logic [7:0] parity_errors; // Saturates at FF.
      logic [7:0] line_errors;   // Saturates at FF.
      logic       overflow;      // Sticky until reset.
      logic       busy;          // A frame is being received.
   } kbd_status_t;

endpackage

// File: ps2_rx.sv
// PS/2 line receiver.
// Synchronizes the clock and data lines, finds clean clock edges,
// shifts in data on falling edges and times the quiet gap that
// closes a frame. Flags truncated frames and a clock held low.
`timescale 1ns/1ps

module ps2_rx import kbd_pkg::*; #(
   parameter int FREQ     = 50000, // System clock in kHz.
   parameter int PS2_FREQ = 10     // PS/2 clock in kHz.
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       ps2_clk,    // Raw keyboard clock.
   input  logic       ps2_data,   // Raw keyboard data.
   output ps2_frame_t frame,      // Valid while rdy is high.
   output logic       rdy,        // One-cycle frame pulse.
   output logic       busy,       // Bits of a frame have arrived.
   output logic       line_error  // One-cycle error pulse.
);

   // Quiet time that ends a frame, in system clock cycles.
   localparam int TIMEOUT = FREQ / PS2_FREQ;
   localparam int TW      = $clog2(TIMEOUT + 2);
   localparam logic [TW-1:0] QUIET_CNT = TW'(TIMEOUT);
   localparam logic [TW-1:0] IDLE_CNT  = TW'(TIMEOUT + 1);

   logic [4:0]    clk_r;         // Clock synchronizer and edge history.
   logic [1:0]    data_r;        // Data synchronizer.
   logic [9:0]    sc_r;          // Shift register, start bit falls out.
   logic [TW-1:0] timer_r;       // Cycles since the last clock edge.
   logic [3:0]    bitcnt_r;      // Falling edges seen in this frame.
   logic          rdy_r;
   logic          error_r;       // Receiver error flag.
   logic          error_pulse_r; // Rising edge of the error flag.

   logic fall_edge;
   logic rise_edge;
   logic clk_edge;
   logic timeout_hit;
   logic quiet;
   logic stuck_low;
   logic idle_high;
   logic error_c;

   // Two stable samples on each side of the transition.
   assign fall_edge = clk_r[4:1] == 4'b1100;
   assign rise_edge = clk_r[4:1] == 4'b0011;
   assign clk_edge  = fall_edge || rise_edge;

   // The timer stops one past TIMEOUT, so the timeout events fire once.
   assign timeout_hit = timer_r == QUIET_CNT;
   assign quiet       = timeout_hit && clk_r[1];  // Clock released and still.
   assign stuck_low   = timeout_hit && !clk_r[1]; // Clock held low too long.
   assign idle_high   = (timer_r == IDLE_CNT) && clk_r[1];

   // Set on a stuck clock or on a partial frame, cleared once the line idles.
   always_comb
   begin
      if (stuck_low || (quiet && bitcnt_r != 4'd0 && bitcnt_r != 4'd11))
         error_c = 1'b1;
      else if (idle_high)
         error_c = 1'b0;
      else
         error_c = error_r;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         clk_r         <= 5'b11111; // Line assumed idle high.
         data_r        <= 2'b11;
         timer_r       <= '0;
         bitcnt_r      <= 4'd0;
         rdy_r         <= 1'b0;
         error_r       <= 1'b0;
         error_pulse_r <= 1'b0;
      end
      else
      begin
         clk_r  <= {clk_r[3:0], ps2_clk};
         data_r <= {data_r[0], ps2_data};

         if (clk_edge)
            timer_r <= '0;
         else if (timer_r != IDLE_CNT)
            timer_r <= timer_r + 1'b1;

         // Count bits, and drop a partial count on quiet or error.
         if (fall_edge)
            bitcnt_r <= bitcnt_r + 4'd1;
         else if (quiet || error_r)
            bitcnt_r <= 4'd0;

         rdy_r         <= quiet && (bitcnt_r == 4'd11); // Full 11-bit frame.
         error_r       <= error_c;
         error_pulse_r <= error_c && !error_r;
      end
   end

   // Data is taken from the synchronized line on the clock's falling edge.
   always_ff @(posedge clk)
   begin
      if (fall_edge)
         sc_r <= {data_r[1], sc_r[9:1]};
   end

   // After 11 shifts: stop in bit 9, parity in bit 8, data in 7:0.
   assign frame      = '{code: sc_r[7:0], parity: sc_r[8]};
   assign rdy        = rdy_r;
   assign busy       = bitcnt_r != 4'd0;
   assign line_error = error_pulse_r;

   // A frame either completes or fails, never both on one cycle.
   a_rdy_err_exclusive: assert property (
      @(posedge clk) disable iff (reset) !(rdy && line_error)
   ) else $error("rdy and line_error high together");

endmodule

// File: scancode_decoder.sv
// Scan code decoder.
// Checks odd parity of each frame, folds the E0 and F0 prefixes
// into a single key event and counts parity and line errors.
`timescale 1ns/1ps

module scancode_decoder import kbd_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  ps2_frame_t frame,         // From the receiver.
   input  logic       rdy,           // Frame strobe.
   input  logic       line_error,    // Receiver error strobe.
   output key_event_t key_event,     // Valid with event_strobe.
   output logic       event_strobe,
   output logic [7:0] parity_errors,
   output logic [7:0] line_errors
);

   logic       ext_r;           // E0 seen, waiting for the code.
   logic       brk_r;           // F0 seen, waiting for the code.
   key_event_t event_r;
   logic       strobe_r;
   logic [7:0] parity_errors_r;
   logic [7:0] line_errors_r;

   logic parity_ok;
   logic is_prefix;

   // Odd parity over data and parity bit.
   assign parity_ok = ^{frame.code, frame.parity};
   assign is_prefix = (frame.code == PREFIX_EXT) || (frame.code == PREFIX_BREAK);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ext_r           <= 1'b0;
         brk_r           <= 1'b0;
         strobe_r        <= 1'b0;
         parity_errors_r <= 8'd0;
         line_errors_r   <= 8'd0;
      end
      else
      begin
         strobe_r <= rdy && parity_ok && !is_prefix;

         if (line_error)
         begin
            // A broken frame leaves the prefix chain meaningless.
            ext_r <= 1'b0;
            brk_r <= 1'b0;
            if (line_errors_r != 8'hFF)
               line_errors_r <= line_errors_r + 8'd1;
         end
         else if (rdy)
         begin
            if (!parity_ok)
            begin
               ext_r <= 1'b0; // Prefix before a bad byte is dropped.
               brk_r <= 1'b0;
               if (parity_errors_r != 8'hFF)
                  parity_errors_r <= parity_errors_r + 8'd1;
            end
            else if (frame.code == PREFIX_EXT)
               ext_r <= 1'b1;
            else if (frame.code == PREFIX_BREAK)
               brk_r <= 1'b1;
            else
            begin
               // Event emitted and the chain starts over.
               ext_r <= 1'b0;
               brk_r <= 1'b0;
            end
         end
      end
   end

   // Event payload qualified by strobe_r.
   always_ff @(posedge clk)
   begin
      if (rdy)
         event_r <= '{extended: ext_r, released: brk_r, code: frame.code};
   end

   assign key_event     = event_r;
   assign event_strobe  = strobe_r;
   assign parity_errors = parity_errors_r;
   assign line_errors   = line_errors_r;

   // Every event follows a single-cycle frame pulse on the cycle before.
   a_strobe_after_rdy: assert property (
      @(posedge clk) disable iff (reset) event_strobe |-> $past(rdy) && !$past(rdy, 2)
   ) else $error("event_strobe without a one-cycle frame pulse one cycle earlier");

endmodule

// File: key_event_fifo.sv
// Key event queue.
// Show-ahead circular buffer: the head is read straight from
// storage while event_ready is high. A push into a full queue
// is dropped and sets a sticky overflow flag.
`timescale 1ns/1ps

module key_event_fifo import kbd_pkg::*; #(
   parameter int FIFO_DEPTH = 8 // Power of two.
) (
   input  logic       clk,
   input  logic       reset,
   input  key_event_t key_event,    // Incoming event.
   input  logic       event_strobe, // Push.
   input  logic       pop,          // Host read strobe.
   output key_event_t head,         // Oldest event.
   output logic       event_ready,  // Queue not empty.
   output logic       overflow      // An event was lost.
);

   localparam int AW = $clog2(FIFO_DEPTH);
   localparam logic [AW:0] FULL_COUNT = (AW + 1)'(FIFO_DEPTH);

   key_event_t    mem [FIFO_DEPTH]; // Event storage.
   logic [AW-1:0] wr_ptr_r;
   logic [AW-1:0] rd_ptr_r;
   logic [AW:0]   count_r;          // Occupancy, 0 to FIFO_DEPTH.
   logic          overflow_r;

   logic full;
   logic do_pop;
   logic do_push;

   assign full    = count_r == FULL_COUNT;
   assign do_pop  = pop && (count_r != '0); // Pop on empty is ignored.
   assign do_push = event_strobe && (!full || do_pop); // A pop frees a slot.

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr_r   <= '0;
         rd_ptr_r   <= '0;
         count_r    <= '0;
         overflow_r <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr_r <= wr_ptr_r + 1'b1; // Wraps, depth is a power of two.
         if (do_pop)
            rd_ptr_r <= rd_ptr_r + 1'b1;

         case ({do_push, do_pop})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r; // Both or neither.
         endcase

         if (event_strobe && !do_push)
            overflow_r <= 1'b1; // Dropped event.
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr_r] <= key_event;
   end

   assign head        = mem[rd_ptr_r]; // Read-through.
   assign event_ready = count_r != '0;
   assign overflow    = overflow_r;

   a_count_bound: assert property (
      @(posedge clk) disable iff (reset) count_r <= FULL_COUNT
   ) else $error("queue occupancy above FIFO_DEPTH");

endmodule

// File: kbd_top.sv
// PS/2 keyboard front end, top level.
// Chains receiver, decoder and event queue, and packs the host
// status word from their counters and flags.
`timescale 1ns/1ps

module kbd_top import kbd_pkg::*; #(
   parameter int FREQ       = 50000, // System clock in kHz.
   parameter int PS2_FREQ   = 10,    // PS/2 clock in kHz.
   parameter int FIFO_DEPTH = 8      // Event queue depth.
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        ps2_clk,
   input  logic        ps2_data,
   input  logic        pop,         // Host takes the head event.
   output key_event_t  head,
   output logic        event_ready,
   output kbd_status_t status
);

   ps2_frame_t frame;
   logic       rdy;
   logic       rx_busy;
   logic       line_error;
   key_event_t key_event;
   logic       event_strobe;
   logic [7:0] parity_errors;
   logic [7:0] line_errors;
   logic       overflow;

   ps2_rx #(
      .FREQ     (FREQ),
      .PS2_FREQ (PS2_FREQ)
   ) ps2_rx_inst (
      .clk        (clk),
      .reset      (reset),
      .ps2_clk    (ps2_clk),
      .ps2_data   (ps2_data),
      .frame      (frame),
      .rdy        (rdy),
      .busy       (rx_busy),
      .line_error (line_error)
   );

   scancode_decoder scancode_decoder_inst (
      .clk           (clk),
      .reset         (reset),
      .frame         (frame),
      .rdy           (rdy),
      .line_error    (line_error),
      .key_event     (key_event),
      .event_strobe  (event_strobe),
      .parity_errors (parity_errors),
      .line_errors   (line_errors)
   );

   key_event_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) key_event_fifo_inst (
      .clk          (clk),
      .reset        (reset),
      .key_event    (key_event),
      .event_strobe (event_strobe),
      .pop          (pop),
      .head         (head),
      .event_ready  (event_ready),
      .overflow     (overflow)
   );

   // Host status word.
   assign status = '{parity_errors: parity_errors,
                     line_errors:   line_errors,
                     overflow:      overflow,
                     busy:          rx_busy};

endmodule

// File: kbd_tb.sv
// Testbench for the PS/2 keyboard front end.
// Reads commands from kbd_tests.txt, drives PS/2 frames into the DUT,
// pops key events and compares events and status with the file.
// Includes a cycle watchdog sized from the number of commands.
`timescale 1ns/1ps

module kbd_tb import kbd_pkg::*; ();

   localparam int HALF_CYCLES    = 6;   // PS/2 half period in clk cycles.
   localparam int IDLE_CYCLES    = 40;  // Lines idle high after a frame.
   localparam int HOLD_CYCLES    = 40;  // Clock held low longer than TIMEOUT.
   localparam int WAIT_CYCLES    = 100; // Longest wait for a queued event.
   localparam int MAX_CMDS       = 64;
   localparam int CYCLES_PER_CMD = 600;

   logic        clk;
   logic        reset;
   logic        ps2_clk;
   logic        ps2_data;
   logic        pop;
   key_event_t  head;
   logic        event_ready;
   kbd_status_t status;

   // Command word with op in 27:24, then fields aa, bb and cc.
   logic [27:0] cmds [0:MAX_CMDS-1];
   int          cmd_count;
   int          cycle_limit;  // Zero until the file has been read.
   int          cycles;

   kbd_top #(
      .FREQ       (2000),
      .PS2_FREQ   (100),  // TIMEOUT of 20 cycles.
      .FIFO_DEPTH (4)
   ) kbd_top_inst (
      .clk         (clk),
      .reset       (reset),
      .ps2_clk     (ps2_clk),
      .ps2_data    (ps2_data),
      .pop         (pop),
      .head        (head),
      .event_ready (event_ready),
      .status      (status)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk; // 4 ns period.
   end

   // Watchdog.
   initial
   begin
      cycles = 0;
      wait (cycle_limit > 0);
      while (cycles < cycle_limit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("sim failed");
      $fatal(1, "Timeout after %0d cycles, the command sequence did not finish.", cycles);
   end

   // Wait n rising edges, then 1 ns so inputs change away from the edge.
   task automatic step(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // Data changes mid-high and the device samples it on the falling clock.
   task automatic send_bit(input logic b);
      ps2_data = b;
      step(HALF_CYCLES / 2);
      ps2_clk = 1'b0;
      step(HALF_CYCLES);
      ps2_clk = 1'b1;
      step(HALF_CYCLES - HALF_CYCLES / 2);
   endtask

   task automatic check_busy(input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("MISMATCH status.busy: got %h expected %h", got, exp);
         $display("sim failed");
         $fatal(1, "Receiver busy flag is wrong.");
      end
   endtask

   // Start, 8 data bits LSB first, parity, stop. nbits below 11 truncates.
   task automatic send_frame(input logic [7:0] code, input logic good_parity,
                             input int nbits);
      logic        par;
      logic [10:0] bits;
      par  = good_parity ? ~(^code) : ^code; // Odd parity when good.
      bits = {1'b1, par, code, 1'b0};
      for (int i = 0; i < nbits; i++)
         send_bit(bits[i]);
      if (nbits > 0)
         check_busy(status.busy, 1'b1); // Bits stay counted until the quiet gap.
      ps2_data = 1'b1;
      step(IDLE_CYCLES);
   endtask

   task automatic hold_clock_low();
      ps2_clk = 1'b0;
      step(HOLD_CYCLES);
      ps2_clk = 1'b1;
      step(IDLE_CYCLES); // Receiver error flag clears once idle.
   endtask

   task automatic check_event(input key_event_t got, input key_event_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH head: got %h expected %h", got, exp);
         $display("sim failed");
         $fatal(1, "Key event at the queue head is wrong.");
      end
   endtask

   task automatic check_status(input kbd_status_t got, input kbd_status_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH status: got %h expected %h", got, exp);
         $display("sim failed");
         $fatal(1, "Status word is wrong.");
      end
   endtask

   task automatic check_ready(input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("MISMATCH event_ready: got %h expected %h", got, exp);
         $display("sim failed");
         $fatal(1, "Queue state is wrong.");
      end
   endtask

   // Bounded wait for an event, compare the head, then one pop strobe.
   task automatic pop_expect(input key_event_t exp);
      int waited;
      waited = 0;
      while (!event_ready && waited < WAIT_CYCLES)
      begin
         step(1);
         waited++;
      end
      if (!event_ready)
      begin
         $display("sim failed");
         $fatal(1, "No key event arrived while waiting for code %h.", exp.code);
      end
      check_event(head, exp);
      pop = 1'b1;
      step(1);
      pop = 1'b0;
   endtask

   initial
   begin
      logic [27:0] w;
      key_event_t  exp_ev;
      kbd_status_t exp_st;
      ps2_clk  = 1'b1; // Idle bus.
      ps2_data = 1'b1;
      pop      = 1'b0;
      reset    = 1'b1;

      $readmemh("kbd_tests.txt", cmds);
      cmd_count = 0;
      while (cmd_count < MAX_CMDS && !$isunknown(cmds[cmd_count]) &&
             cmds[cmd_count][27:24] != 4'hF)
         cmd_count++;
      if (cmd_count == 0)
      begin
         $display("sim failed");
         $fatal(1, "No commands could be read from the test file.");
      end
      cycle_limit = CYCLES_PER_CMD * (cmd_count + 1); // One extra for reset.

      step(8);
      reset = 1'b0;
      step(2);

      for (int i = 0; i < cmd_count; i++)
      begin
         w = cmds[i];
         case (w[27:24])
            4'h1: send_frame(w[7:0], 1'b1, 11);
            4'h2: send_frame(w[7:0], 1'b0, 11);
            4'h3: send_frame(8'hA5, 1'b1, int'(w[23:16]));
            4'h4: hold_clock_low();
            4'h5:
            begin
               exp_ev = '{extended: w[16], released: w[8], code: w[7:0]};
               pop_expect(exp_ev);
            end
            4'h6:
            begin
               exp_st = '{parity_errors: w[23:16], line_errors: w[15:8],
                          overflow: w[0], busy: 1'b0}; // Lines are idle here.
               check_status(status, exp_st);
            end
            4'h7: check_ready(event_ready, 1'b0);
            default:
            begin
               $display("sim failed");
               $fatal(1, "Unknown command %h at entry %0d of the test file.", w, i);
            end
         endcase
      end

      $display("sim passed");
      $finish;
   end

endmodule

// File: kbd_tests.txt
// Columns op_aa_bb_cc in hex. op 1 send cc, 2 send cc with bad parity,
// 3 truncated frame of aa bits, 4 hold clock low, 5 pop and expect ext aa
// rel bb code cc, 6 expect parity errs aa line errs bb overflow cc,
// 7 expect empty queue, F end of commands.
// Plain make code.
1_00_00_1C
5_00_00_1C
7_00_00_00
// Extended release, then release only.
1_00_00_E0
1_00_00_F0
1_00_00_75
5_01_01_75
7_00_00_00
1_00_00_F0
1_00_00_1C
5_00_01_1C
7_00_00_00
6_00_00_00
// Bad parity, then a release prefix broken by a bad byte.
2_00_00_2A
6_01_00_00
7_00_00_00
1_00_00_F0
2_00_00_33
1_00_00_33
5_00_00_33
7_00_00_00
6_02_00_00
// Truncated frame and held clock.
3_06_00_00
6_02_01_00
4_00_00_00
6_02_02_00
1_00_00_4B
5_00_00_4B
7_00_00_00
// Six events into a queue of four.
1_00_00_16
1_00_00_1E
1_00_00_26
1_00_00_25
1_00_00_2E
1_00_00_36
6_02_02_01
5_00_00_16
5_00_00_1E
5_00_00_26
5_00_00_25
7_00_00_00
F_00_00_00

// File: vlog.f
kbd_pkg.sv
ps2_rx.sv
scancode_decoder.sv
key_event_fifo.sv
kbd_top.sv
kbd_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the PS/2 keyboard testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module kbd_tb -o kbd_sim
./obj_dir/kbd_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "sim failed" sim.log; then
   echo "Simulation FAILED"
   exit 1
fi
echo "Simulation PASSED"
